// ==== filelist.f ====
rv_pkg.sv
main_decoder.sv
alu_decoder.sv
register_file.sv
decode_stage.sv
stage_buffer.sv
alu.sv
exec_core.sv
tb_exec_core.sv

// ==== Bender.yml ====
package:
  name: exec_core

sources:
  - rv_pkg.sv
  - main_decoder.sv
  - alu_decoder.sv
  - register_file.sv
  - decode_stage.sv
  - stage_buffer.sv
  - alu.sv
  - exec_core.sv
  - target: test
    files:
      - tb_exec_core.sv

// ==== tb_exec_core.sv ====
module tb_exec_core;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_pkg::*;

    localparam int NUM_INSTR  = 400;
    localparam int MAX_CYCLES = 1200;       // About 470 issue slots plus idle gaps
    localparam int K_FULL     = 0;
    localparam int K_BR       = 1;          // Branch, rd field holds immediate bits
    localparam int K_READ     = 2;          // Register read back through ADD x0

    logic            clk_i;
    logic            rst_n_i;
    logic [31:0]     instr_i;
    logic            instr_valid_i;
    logic            res_valid_o;
    logic [4:0]      res_rd_o;
    logic [XLEN-1:0] res_data_o;
    logic            res_branch_taken_o;
    logic            res_illegal_o;

    integer          seed;
    int              cycle_count = 0;
    logic [XLEN-1:0] model_regs [32];
    wb_t             exp_q [$];
    int              kind_q [$];
    int              src_q [$];

    exec_core #(.XLEN(XLEN)) u_dut (.*);

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    task automatic report_error(input string msg);
        $display("ERR %0d ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_wb(input wb_t exp, input int kind);
        wb_t   got;
        string msg;
        got = '{rd: res_rd_o, result: res_data_o, reg_write: exp.reg_write,
                branch_taken: res_branch_taken_o, illegal: res_illegal_o};
        if (got.illegal !== exp.illegal || got.result !== exp.result ||
            got.branch_taken !== exp.branch_taken ||
            (kind != K_BR && got.rd !== exp.rd)) begin
            msg = {$sformatf("got rd %0d data %h taken %b illegal %b, ",
                             got.rd, got.result, got.branch_taken, got.illegal),
                   $sformatf("exp rd %0d data %h taken %b illegal %b",
                             exp.rd, exp.result, exp.branch_taken, exp.illegal)};
            report_error(msg);
        end
    endtask

    task automatic check_reg(input logic [XLEN-1:0] value, input int rn,
                             input logic [XLEN-1:0] expected);
        if (value !== expected) begin
            report_error($sformatf("x%0d reads %h, expected %h", rn, value, expected));
        end
    endtask

    // Reference ALU from the RV32I rules, alt selects SUB or SRA
    function automatic logic [XLEN-1:0] alu_model(input logic [2:0] f3, input logic alt,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 1 : 0;
            3'd3:    return (a < b) ? 1 : 0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? XLEN'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // One call per cycle, the edge after the drive samples it
    task automatic issue(input logic [31:0] instr, input wb_t exp, input int kind, input int src);
        @(posedge clk_i);
        #2;
        instr_i       = instr;
        instr_valid_i = 1'b1;
        exp_q.push_back(exp);
        kind_q.push_back(kind);
        src_q.push_back(src);
    endtask

    task automatic idle();
        @(posedge clk_i);
        #2;
        instr_valid_i = 1'b0;
        instr_i       = $random(seed);      // Garbage while not valid
    endtask

    task automatic read_back(input int rn);
        wb_t exp;
        exp = '{rd: 5'd0, result: model_regs[rn], reg_write: 1'b1, branch_taken: 1'b0,
                illegal: 1'b0};
        issue({7'h00, 5'd0, 5'(rn), 3'd0, 5'd0, OPC_OP}, exp, K_READ, rn);
    endtask

    task automatic issue_random();
        logic [31:0]     instr;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [2:0]      f3;
        logic [2:0]      bad_f3;
        logic [6:0]      f7;
        logic [6:0]      opc;
        logic [11:0]     imm;
        logic            alt;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        wb_t             exp;
        int              pick;
        int              kind;
        pick = $unsigned($random(seed)) % 10;
        rd   = $random(seed) & 7;           // x0 to x7 for frequent dependences
        rs1  = $random(seed) & 7;
        rs2  = $random(seed) & 7;
        f3   = $random(seed);
        f7   = $random(seed) | 7'h01;       // Never 0x00 or 0x20
        imm  = $random(seed);
        alt  = $random(seed);
        a    = model_regs[rs1];
        b    = model_regs[rs2];
        exp    = '0;
        exp.rd = rd;
        kind   = K_FULL;
        if (pick < 3) begin
            alt = alt & (f3 == 3'd0 || f3 == 3'd5);
            instr = {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, OPC_OP};
            exp.result    = alu_model(f3, alt, a, b);
            exp.reg_write = 1'b1;
        end else if (pick < 6) begin
            alt = alt & (f3 == 3'd5);
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm[11:5] = alt ? 7'h20 : 7'h00;
            end
            instr = {imm, rs1, f3, rd, OPC_OP_IMM};
            exp.result    = alu_model(f3, alt, a, {{(XLEN-12){imm[11]}}, imm});
            exp.reg_write = 1'b1;
        end else if (pick < 8) begin
            instr = {f7, rs2, rs1, {2'b00, alt}, rd, OPC_BRANCH};    // BEQ or BNE
            exp.result       = a - b;
            exp.branch_taken = (a == b) ^ alt;
            kind             = K_BR;
        end else begin
            exp.illegal = 1'b1;
            case ($unsigned($random(seed)) % 4)
                0: instr = {f7, rs2, rs1, f3, rd, OPC_OP};
                1: instr = {f7, rs2, rs1, alt ? 3'd1 : 3'd5, rd, OPC_OP_IMM};
                2: begin
                    bad_f3 = 3'd2 + 3'($unsigned($random(seed)) % 6);
                    instr  = {f7, rs2, rs1, bad_f3, rd, OPC_BRANCH};
                    kind   = K_BR;
                end
                default: begin
                    opc = $random(seed);
                    if (opc == OPC_OP || opc == OPC_OP_IMM || opc == OPC_BRANCH) begin
                        opc = opc ^ 7'h04;   // Lands on LUI, AUIPC or JALR
                    end
                    instr = {f7, rs2, rs1, f3, rd, opc};
                end
            endcase
        end
        if (exp.reg_write && rd != 5'd0) begin
            model_regs[rd] = exp.result;
        end
        issue(instr, exp, kind, 0);
    endtask

    // Outputs settle after the rising edge
    always @(negedge clk_i) begin
        if (rst_n_i && res_valid_o) begin
            if (exp_q.size() == 0) begin
                report_error("result valid with no instruction in flight");
            end else begin
                if (kind_q[0] == K_READ) begin
                    check_reg(res_data_o, src_q[0], exp_q[0].result);
                end
                check_wb(exp_q[0], kind_q[0]);
                void'(exp_q.pop_front());
                void'(kind_q.pop_front());
                void'(src_q.pop_front());
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d results still pending",
                     cycle_count, exp_q.size());
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        seed          = 32'hce84b119;
        rst_n_i       = 1'b0;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        for (int r = 0; r < 32; r++) begin
            read_back(r);                   // All zero after reset
        end
        for (int n = 0; n < NUM_INSTR; n++) begin
            if ($unsigned($random(seed)) % 4 == 0) begin
                repeat (1 + $unsigned($random(seed)) % 3) idle();
            end
            issue_random();
        end
        for (int r = 0; r < 32; r++) begin
            read_back(r);
        end
        idle();
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (4) @(posedge clk_i);        // Catch stray result strobes
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== exec_core.sv ====
module exec_core #(
    parameter int XLEN = rv_pkg::XLEN
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic [31:0]      instr_i,
    input  logic             instr_valid_i,
    output logic             res_valid_o,
    output logic [4:0]       res_rd_o,
    output logic [XLEN-1:0]  res_data_o,
    output logic             res_branch_taken_o,
    output logic             res_illegal_o
);

    import rv_pkg::*;

    logic [4:0]      raddr_a;
    logic [4:0]      raddr_b;
    logic [XLEN-1:0] rdata_a;
    logic [XLEN-1:0] rdata_b;
    ex_req_t         dec_req;
    logic            dec_valid;
    ex_req_t         ex_req;
    logic            ex_valid;
    wb_t             alu_wb;
    logic            rf_we;
    wb_t             wb_q;

    decode_stage #(.XLEN(XLEN)) u_decode (
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .raddr_a_o     (raddr_a),
        .raddr_b_o     (raddr_b),
        .rdata_a_i     (rdata_a),
        .rdata_b_i     (rdata_b),
        .req_o         (dec_req),
        .req_valid_o   (dec_valid)
    );

    register_file #(.XLEN(XLEN)) u_regfile (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (raddr_a),
        .raddr_b_i (raddr_b),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .we_i      (rf_we),
        .waddr_i   (alu_wb.rd),
        .wdata_i   (alu_wb.result)          // Written at the end of the ALU cycle
    );

    stage_buffer #(.payload_t(ex_req_t)) u_ex_buf (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (dec_valid),
        .data_i  (dec_req),
        .valid_o (ex_valid),
        .data_o  (ex_req)
    );

    alu #(.XLEN(XLEN)) u_alu (
        .req_i       (ex_req),
        .req_valid_i (ex_valid),
        .wb_o        (alu_wb),
        .we_o        (rf_we)
    );

    stage_buffer #(.payload_t(wb_t)) u_wb_buf (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (ex_valid),
        .data_i  (alu_wb),
        .valid_o (res_valid_o),
        .data_o  (wb_q)
    );

    assign res_rd_o           = wb_q.rd;
    assign res_data_o         = wb_q.result;
    assign res_branch_taken_o = wb_q.branch_taken;
    assign res_illegal_o      = wb_q.illegal;

endmodule

// ==== alu.sv ====
module alu #(
    parameter int XLEN = rv_pkg::XLEN
) (
    input  rv_pkg::ex_req_t  req_i,
    input  logic             req_valid_i,
    output rv_pkg::wb_t      wb_o,
    output logic             we_o           // Register file write enable
);

    import rv_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] result;
    logic [4:0]      shamt;
    logic            zero;

    assign op_a  = req_i.op_a;
    assign op_b  = req_i.op_b;
    assign shamt = op_b[4:0];               // Only the low 5 bits shift

    always_comb begin
        case (req_i.alu_ctrl)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_SLL:  result = op_a << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_SRL:  result = op_a >> shamt;
            ALU_SRA:  result = $unsigned($signed(op_a) >>> shamt);  // Keeps sign bit
            ALU_OR:   result = op_a | op_b;
            ALU_XOR:  result = op_a ^ op_b;
            ALU_AND:  result = op_a & op_b;
            default:  result = '0;          // PASS_ZERO
        endcase
    end

    assign zero = (result == '0);

    always_comb begin
        wb_o.rd           = req_i.rd;
        wb_o.result       = result;         // Difference for branches
        wb_o.reg_write    = req_i.reg_write;
        wb_o.branch_taken = req_i.is_branch & (zero ^ req_i.branch_ne);
        wb_o.illegal      = req_i.illegal;
    end

    assign we_o = req_valid_i & req_i.reg_write & (req_i.rd != 5'd0);

endmodule

// ==== stage_buffer.sv ====
module stage_buffer #(
    parameter type payload_t = logic
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      valid_i,
    input  payload_t  data_i,
    output logic      valid_o,
    output payload_t  data_o
);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;             // One strobe per accepted entry
        end
    end

    // Payload follows the input on every edge
    always_ff @(posedge clk_i) begin
        data_o <= data_i;
    end

endmodule

// ==== decode_stage.sv ====
module decode_stage #(
    parameter int XLEN = rv_pkg::XLEN
) (
    input  logic [31:0]      instr_i,
    input  logic             instr_valid_i,
    output logic [4:0]       raddr_a_o,
    output logic [4:0]       raddr_b_o,
    input  logic [XLEN-1:0]  rdata_a_i,
    input  logic [XLEN-1:0]  rdata_b_i,
    output rv_pkg::ex_req_t  req_o,
    output logic             req_valid_o
);

    import rv_pkg::*;

    alu_op_e         alu_op;
    logic            use_imm;
    logic            reg_write;
    logic            is_branch;
    logic [XLEN-1:0] imm;
    alu_ctrl_e       alu_ctrl;
    logic            ctrl_illegal;
    logic            branch_illegal;
    logic            illegal;

    main_decoder #(.XLEN(XLEN)) u_main_dec (
        .instr_i     (instr_i),
        .alu_op_o    (alu_op),
        .use_imm_o   (use_imm),
        .reg_write_o (reg_write),
        .is_branch_o (is_branch),
        .imm_o       (imm)
    );

    alu_decoder u_alu_dec (
        .alu_op_i      (alu_op),
        .funct3_i      (instr_i[14:12]),
        .funct7_i      (instr_i[31:25]),
        .alu_control_o (alu_ctrl),
        .illegal_o     (ctrl_illegal)
    );

    assign raddr_a_o = instr_i[19:15];      // rs1
    assign raddr_b_o = instr_i[24:20];      // rs2

    // Only BEQ and BNE are supported
    assign branch_illegal = is_branch & (instr_i[14:13] != 2'b00);
    assign illegal        = ctrl_illegal | branch_illegal;

    always_comb begin
        req_o.alu_ctrl  = illegal ? ALU_PASS_ZERO : alu_ctrl;
        req_o.op_a      = rdata_a_i;
        req_o.op_b      = use_imm ? imm : rdata_b_i;
        req_o.rd        = instr_i[11:7];
        req_o.reg_write = reg_write & ~illegal;
        req_o.is_branch = is_branch & ~illegal;
        req_o.branch_ne = instr_i[12];      // funct3 1 is BNE
        req_o.illegal   = illegal;
    end

    assign req_valid_o = instr_valid_i;

endmodule

// ==== register_file.sv ====
module register_file #(
    parameter int XLEN = rv_pkg::XLEN
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic [4:0]       raddr_a_i,
    input  logic [4:0]       raddr_b_i,
    output logic [XLEN-1:0]  rdata_a_o,
    output logic [XLEN-1:0]  rdata_b_o,
    input  logic             we_i,
    input  logic [4:0]       waddr_i,
    input  logic [XLEN-1:0]  wdata_i
);

    logic [XLEN-1:0] regs [1:31];           // x0 has no storage

    // Write data bypasses the array so the next decode sees it
    always_comb begin
        if (raddr_a_i == 5'd0) begin
            rdata_a_o = '0;
        end else if (we_i && (waddr_i == raddr_a_i)) begin
            rdata_a_o = wdata_i;
        end else begin
            rdata_a_o = regs[raddr_a_i];
        end
    end

    always_comb begin
        if (raddr_b_i == 5'd0) begin
            rdata_b_o = '0;
        end else if (we_i && (waddr_i == raddr_b_i)) begin
            rdata_b_o = wdata_i;
        end else begin
            rdata_b_o = regs[raddr_b_i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i;       // x0 writes dropped
        end
    end

endmodule

// ==== alu_decoder.sv ====
module alu_decoder (
    input  rv_pkg::alu_op_e   alu_op_i,     // Class from the main decoder
    input  logic [2:0]        funct3_i,
    input  logic [6:0]        funct7_i,
    output rv_pkg::alu_ctrl_e alu_control_o,
    output logic              illegal_o
);

    import rv_pkg::*;

    always_comb begin
        alu_control_o = ALU_PASS_ZERO;
        illegal_o     = 1'b0;
        case (alu_op_i)
            OP_IMM: begin
                case (funct3_i)
                    3'h0: alu_control_o = ALU_ADD;     // ADDI
                    3'h2: alu_control_o = ALU_SLT;     // SLTI
                    3'h3: alu_control_o = ALU_SLTU;    // SLTIU
                    3'h4: alu_control_o = ALU_XOR;     // XORI
                    3'h6: alu_control_o = ALU_OR;      // ORI
                    3'h7: alu_control_o = ALU_AND;     // ANDI
                    3'h1: begin
                        if (funct7_i == 7'h00) begin
                            alu_control_o = ALU_SLL;   // SLLI
                        end else begin
                            illegal_o = 1'b1;
                        end
                    end
                    default: begin                     // funct3 5
                        if (funct7_i == 7'h00) begin
                            alu_control_o = ALU_SRL;   // SRLI
                        end else if (funct7_i == 7'h20) begin
                            alu_control_o = ALU_SRA;   // SRAI
                        end else begin
                            illegal_o = 1'b1;
                        end
                    end
                endcase
            end

            OP_BRANCH: begin
                alu_control_o = ALU_SUB;               // Zero result means equal
            end

            OP_REG: begin
                case ({funct7_i, funct3_i})
                    {7'h00, 3'h0}: alu_control_o = ALU_ADD;
                    {7'h20, 3'h0}: alu_control_o = ALU_SUB;
                    {7'h00, 3'h1}: alu_control_o = ALU_SLL;
                    {7'h00, 3'h2}: alu_control_o = ALU_SLT;
                    {7'h00, 3'h3}: alu_control_o = ALU_SLTU;
                    {7'h00, 3'h4}: alu_control_o = ALU_XOR;
                    {7'h00, 3'h5}: alu_control_o = ALU_SRL;
                    {7'h20, 3'h5}: alu_control_o = ALU_SRA;
                    {7'h00, 3'h6}: alu_control_o = ALU_OR;
                    {7'h00, 3'h7}: alu_control_o = ALU_AND;
                    default:       illegal_o     = 1'b1;  // Bad funct7
                endcase
            end

            default: begin
                // NONE only comes from an unknown opcode
                illegal_o = 1'b1;
            end
        endcase
    end

endmodule

// ==== main_decoder.sv ====
module main_decoder #(
    parameter int XLEN = rv_pkg::XLEN
) (
    input  logic [31:0]      instr_i,
    output rv_pkg::alu_op_e  alu_op_o,      // Operation class for the ALU decoder
    output logic             use_imm_o,     // Operand B from the immediate
    output logic             reg_write_o,
    output logic             is_branch_o,
    output logic [XLEN-1:0]  imm_o          // Sign-extended I-type immediate
);

    import rv_pkg::*;

    logic [6:0] opcode;

    assign opcode = instr_i[6:0];

    // I-type immediate, sign bit is instr[31]
    assign imm_o = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};

    always_comb begin
        alu_op_o    = OP_NONE;
        use_imm_o   = 1'b0;
        reg_write_o = 1'b0;
        is_branch_o = 1'b0;
        case (opcode)
            OPC_OP: begin
                alu_op_o    = OP_REG;
                reg_write_o = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_op_o    = OP_IMM;
                use_imm_o   = 1'b1;
                reg_write_o = 1'b1;
            end
            OPC_BRANCH: begin
                alu_op_o    = OP_BRANCH;    // Compare rs1 against rs2
                is_branch_o = 1'b1;
            end
            default: begin
                alu_op_o    = OP_NONE;      // No write for unknown opcodes
            end
        endcase
    end

endmodule

// ==== rv_pkg.sv ====
package rv_pkg;

    parameter int XLEN = 32;                // Data path width

    // ALU control codes, numbered as the control decoder emits them
    typedef enum logic [3:0] {
        ALU_ADD       = 4'h0,
        ALU_SUB       = 4'h1,
        ALU_SLL       = 4'h2,
        ALU_SLT       = 4'h3,
        ALU_SLTU      = 4'h4,
        ALU_SRL       = 4'h5,
        ALU_SRA       = 4'h6,
        ALU_OR        = 4'h7,
        ALU_XOR       = 4'h8,
        ALU_AND       = 4'h9,
        ALU_PASS_ZERO = 4'hA                // Result forced to zero
    } alu_ctrl_e;

    typedef enum logic [1:0] {
        OP_IMM    = 2'd0,                   // I-type ALU
        OP_BRANCH = 2'd1,                   // B-type compare
        OP_REG    = 2'd2,                   // R-type
        OP_NONE   = 2'd3                    // Unknown opcode
    } alu_op_e;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef struct packed {
        alu_ctrl_e         alu_ctrl;
        logic [XLEN-1:0]   op_a;
        logic [XLEN-1:0]   op_b;            // rs2 or immediate
        logic [4:0]        rd;
        logic              reg_write;
        logic              is_branch;
        logic              branch_ne;       // Set for BNE
        logic              illegal;
    } ex_req_t;

    typedef struct packed {
        logic [4:0]        rd;
        logic [XLEN-1:0]   result;
        logic              reg_write;
        logic              branch_taken;
        logic              illegal;
    } wb_t;

endpackage
